//--- verilog/ifu_cfg.svh
// Fetch unit configuration: widths, opcodes, NOP words, error tags, vectors
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// Fetch address and data width
`define IFU_AW 32

// Unconditional jump, 26-bit word displacement
`define IFU_OP_JMP 6'h00

// NOP shown while no word has arrived yet
`define IFU_NOP_BUBBLE 32'h1461_0000
// NOP for flushed slots and faulting fetches
`define IFU_NOP_FLUSH 32'h1441_0000

// Error tags from the instruction memory
`define IFU_TAG_TE 4'hd
`define IFU_TAG_PE 4'hc
`define IFU_TAG_BE 4'hb

// Per-cause offsets from the exception base
`define IFU_VEC_TE 32'h0000_0a00
`define IFU_VEC_PE 32'h0000_0400
`define IFU_VEC_BE 32'h0000_0200

// Vector register values out of reset
`define IFU_RST_VEC 32'h0000_0100
`define IFU_EXC_BASE_RST 32'h0000_0000

`endif

//--- verilog/ifu_pkg.sv
// Shared types of the instruction fetch unit
`include "ifu_cfg.svh"

package ifu_pkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction word, raw or split for jump predecode
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0]  opcode;
		// Word displacement, signed
		logic [25:0] disp;
	} insn_fields_t;

	typedef union packed {
		logic [31:0]  raw;
		insn_fields_t f;
	} insn_u;

	//////////////////////////////////////////////////////////////////////
	// Port to stage response, 70 bits
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic              ack;
		logic              err;
		logic [3:0]        tag;
		logic [31:0]       data;
		// Address the word was fetched from
		logic [`IFU_AW-1:0] addr;
	} imem_rsp_t;

	// Stage output to the core and the PC generator
	typedef struct packed {
		logic              valid;
		logic [`IFU_AW-1:0] pc;
		insn_u             insn;
		// ITLB miss, protection fault, bus error
		logic              te;
		logic              pe;
		logic              be;
	} fetch_out_t;

	// Configuration register write
	typedef struct packed {
		logic        en;
		// 0 reset vector, 1 exception base
		logic        sel;
		logic [31:0] data;
	} cfg_wr_t;

endpackage

//--- verilog/ifu_cfg_regs.sv
// Reset vector and exception base registers behind a small write port
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_cfg_regs (
	input  logic                clk,
	input  logic                rst_n_i,
	input  ifu_pkg::cfg_wr_t    cfg_wr_i,
	output logic [`IFU_AW-1:0]  reset_vec_o,
	output logic [`IFU_AW-1:0]  exc_base_o
);

	// Vector registers
	logic [`IFU_AW-1:0] rst_vec_q;
	logic [`IFU_AW-1:0] exc_base_q;

	// Write strobes per register
	logic wr_rst_vec;
	logic wr_exc_base;

	assign wr_rst_vec  = cfg_wr_i.en & ~cfg_wr_i.sel;
	assign wr_exc_base = cfg_wr_i.en & cfg_wr_i.sel;

	// Reset vector, forced onto a word boundary
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rst_vec_q <= `IFU_RST_VEC;
		end else if (wr_rst_vec) begin
			rst_vec_q <= {cfg_wr_i.data[`IFU_AW-1:2], 2'b00};
		end
	end

	// Exception base, also word aligned
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exc_base_q <= `IFU_EXC_BASE_RST;
		end else if (wr_exc_base) begin
			exc_base_q <= {cfg_wr_i.data[`IFU_AW-1:2], 2'b00};
		end
	end

	// Straight to the PC generator
	assign reset_vec_o = rst_vec_q;
	assign exc_base_o  = exc_base_q;

endmodule

//--- verilog/ifu_pc_gen.sv
// Program counter: boot vector, sequential advance, jump predecode, traps, flush
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_pc_gen (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic [`IFU_AW-1:0]   reset_vec_i,
	input  logic [`IFU_AW-1:0]   exc_base_i,
	input  ifu_pkg::fetch_out_t  fetch_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic [`IFU_AW-1:0]   flush_pc_i,
	output logic [`IFU_AW-1:0]   pc_o,
	output logic                 advance_o
);

	// First cycle after reset, pc comes from the vector register
	logic boot_q;
	logic [`IFU_AW-1:0] pc_q;
	logic [`IFU_AW-1:0] pc_next;
	logic [`IFU_AW-1:0] jmp_off;
	logic consume;

	// Word taken by the core this cycle
	assign consume = fetch_i.valid & ~freeze_i;

	// Flush also moves the port on
	assign advance_o = consume | flush_i;

	// Byte offset of a jump, sign extended
	assign jmp_off = {{(`IFU_AW-28){fetch_i.insn.f.disp[25]}}, fetch_i.insn.f.disp, 2'b00};

	//////////////////////////////////////////////////////////////////////
	// Next pc selection
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Fall through by default
		pc_next = fetch_i.pc + `IFU_AW'd4;
		if (fetch_i.te) begin
			pc_next = exc_base_i + `IFU_VEC_TE;
		end else if (fetch_i.pe) begin
			pc_next = exc_base_i + `IFU_VEC_PE;
		end else if (fetch_i.be) begin
			pc_next = exc_base_i + `IFU_VEC_BE;
		end else if (fetch_i.insn.f.opcode == `IFU_OP_JMP) begin
			// Skip straight to the target
			pc_next = fetch_i.pc + jmp_off;
		end
	end

	// Boot flag lasts one cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			boot_q <= 1'b1;
		end else begin
			boot_q <= 1'b0;
		end
	end

	// Flush beats everything
	always_ff @(posedge clk) begin
		if (flush_i) begin
			pc_q <= flush_pc_i;
		end else if (boot_q) begin
			pc_q <= reset_vec_i;
		end else if (consume) begin
			pc_q <= pc_next;
		end
	end

	// Vector shows through until pc_q holds it
	assign pc_o = boot_q ? reset_vec_i : pc_q;

endmodule

//--- verilog/ifu_imem_port.sv
// Four-phase req/ack master to instruction memory, one fetch in flight
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_imem_port (
	input  logic                clk,
	input  logic                rst_n_i,
	input  logic [`IFU_AW-1:0]  pc_i,
	input  logic                advance_i,
	input  logic                flush_i,
	output logic                mem_req_o,
	output logic [`IFU_AW-1:0]  mem_addr_o,
	input  logic                mem_ack_i,
	input  logic [31:0]         mem_data_i,
	input  logic                mem_err_i,
	input  logic [3:0]          mem_tag_i,
	output ifu_pkg::imem_rsp_t  rsp_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_ACKLO,
		ST_CONS
	} state_e;

	state_e state_q, state_d;
	// Address frozen after the first request cycle
	logic hold_q;
	logic [`IFU_AW-1:0] addr_q;
	// Flushed while request open
	logic drop_q;
	// Consumed or flushed while ack still high
	logic done_q;
	logic pulse_q;
	ifu_pkg::imem_rsp_t rsp_q;
	logic capture;

	//////////////////////////////////////////////////////////////////////
	// Handshake FSM
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: state_d = ST_REQ;
			ST_REQ: if (mem_ack_i) state_d = ST_ACKLO;
			ST_ACKLO: begin
				// Memory must release ack first
				if (!mem_ack_i) begin
					if (advance_i) state_d = ST_REQ;
					else if (done_q || drop_q) state_d = ST_IDLE;
					else state_d = ST_CONS;
				end
			end
			ST_CONS: if (advance_i) state_d = ST_REQ;
			default: state_d = ST_IDLE;
		endcase
	end

	assign capture = (state_q == ST_REQ) & mem_ack_i;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			hold_q  <= 1'b0;
			drop_q  <= 1'b0;
			done_q  <= 1'b0;
			pulse_q <= 1'b0;
		end else begin
			state_q <= state_d;
			hold_q  <= (state_q == ST_REQ) && (state_d == ST_REQ);
			// Response pulse unless flushed
			pulse_q <= capture & ~drop_q & ~flush_i;
			// Flags belong to one transaction, cleared on any new state but ack low wait
			if (state_d != state_q && state_d != ST_ACKLO) begin
				drop_q <= 1'b0;
				done_q <= 1'b0;
			end else begin
				if (state_q == ST_REQ && flush_i) drop_q <= 1'b1;
				if (state_q == ST_ACKLO && advance_i) done_q <= 1'b1;
			end
		end
	end

	// Payload, no reset
	always_ff @(posedge clk) begin
		addr_q <= mem_addr_o;
		if (capture) begin
			rsp_q.ack  <= ~mem_err_i;
			rsp_q.err  <= mem_err_i;
			rsp_q.tag  <= mem_tag_i;
			rsp_q.data <= mem_data_i;
			rsp_q.addr <= mem_addr_o;
		end
	end

	assign mem_req_o  = (state_q == ST_REQ);
	assign mem_addr_o = hold_q ? addr_q : pc_i;

	// Ack and err only in the pulse cycle
	always_comb begin
		rsp_o     = rsp_q;
		rsp_o.ack = pulse_q & rsp_q.ack;
		rsp_o.err = pulse_q & rsp_q.err;
	end

endmodule

//--- verilog/ifu_stage.sv
// Fetch stage: holds the word under freeze, decodes error tags, inserts bubbles
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_stage (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  ifu_pkg::imem_rsp_t   rsp_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	output ifu_pkg::fetch_out_t  fetch_o
);

	// Response present this cycle
	logic live;
	logic save;
	logic saved_q;
	logic [31:0] insn_saved;
	logic [`IFU_AW-1:0] addr_saved;
	// te, pe, be
	logic [2:0] err_saved;
	logic [2:0] err_live;
	logic [31:0] insn_live;

	assign live = rsp_i.ack | rsp_i.err;

	// Keep it only if the core is frozen
	assign save = live & freeze_i & ~flush_i;

	//////////////////////////////////////////////////////////////////////
	// Error tag decode
	//////////////////////////////////////////////////////////////////////

	assign err_live[0] = rsp_i.err & (rsp_i.tag == `IFU_TAG_TE);
	assign err_live[1] = rsp_i.err & (rsp_i.tag == `IFU_TAG_PE);
	assign err_live[2] = rsp_i.err & (rsp_i.tag == `IFU_TAG_BE);

	// Faulting fetch never passes its data
	assign insn_live = rsp_i.err ? `IFU_NOP_FLUSH : rsp_i.data;

	//////////////////////////////////////////////////////////////////////
	// Save register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			saved_q <= 1'b0;
		end else if (flush_i) begin
			saved_q <= 1'b0;
		end else if (save) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			// Consumed
			saved_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved <= insn_live;
			addr_saved <= {rsp_i.addr[`IFU_AW-1:2], 2'b00};
			err_saved  <= err_live;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		fetch_o.valid    = (saved_q | live) & ~flush_i;
		fetch_o.pc       = saved_q ? addr_saved : {rsp_i.addr[`IFU_AW-1:2], 2'b00};
		fetch_o.insn.raw = `IFU_NOP_BUBBLE;
		{fetch_o.be, fetch_o.pe, fetch_o.te} = 3'b000;
		if (flush_i) begin
			// Slot killed
			fetch_o.insn.raw = `IFU_NOP_FLUSH;
		end else if (saved_q) begin
			fetch_o.insn.raw = insn_saved;
			{fetch_o.be, fetch_o.pe, fetch_o.te} = err_saved;
		end else if (live) begin
			fetch_o.insn.raw = insn_live;
			{fetch_o.be, fetch_o.pe, fetch_o.te} = err_live;
		end
	end

endmodule

//--- verilog/ifu_top.sv
// Instruction fetch unit top: config regs, PC generator, memory port, stage
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_top (
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  ifu_pkg::cfg_wr_t     cfg_wr_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic [`IFU_AW-1:0]   flush_pc_i,
	output logic                 mem_req_o,
	output logic [`IFU_AW-1:0]   mem_addr_o,
	input  logic                 mem_ack_i,
	input  logic [31:0]          mem_data_i,
	input  logic                 mem_err_i,
	input  logic [3:0]           mem_tag_i,
	output ifu_pkg::fetch_out_t  fetch_o
);

	logic [`IFU_AW-1:0] reset_vec;
	logic [`IFU_AW-1:0] exc_base;
	logic [`IFU_AW-1:0] pc;
	logic               advance;
	ifu_pkg::imem_rsp_t rsp;

	// Vector registers
	ifu_cfg_regs u_cfg_regs (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.cfg_wr_i    (cfg_wr_i),
		.reset_vec_o (reset_vec),
		.exc_base_o  (exc_base)
	);

	ifu_pc_gen u_pc_gen (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.reset_vec_i (reset_vec),
		.exc_base_i  (exc_base),
		.fetch_i     (fetch_o),
		.freeze_i    (freeze_i),
		.flush_i     (flush_i),
		.flush_pc_i  (flush_pc_i),
		.pc_o        (pc),
		.advance_o   (advance)
	);

	// Memory side
	ifu_imem_port u_imem_port (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.pc_i       (pc),
		.advance_i  (advance),
		.flush_i    (flush_i),
		.mem_req_o  (mem_req_o),
		.mem_addr_o (mem_addr_o),
		.mem_ack_i  (mem_ack_i),
		.mem_data_i (mem_data_i),
		.mem_err_i  (mem_err_i),
		.mem_tag_i  (mem_tag_i),
		.rsp_o      (rsp)
	);

	ifu_stage u_stage (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.rsp_i    (rsp),
		.freeze_i (freeze_i),
		.flush_i  (flush_i),
		.fetch_o  (fetch_o)
	);

endmodule

//--- sim/ifu_assert.sv
// Handshake and stage hold properties, bound into the memory port and the stage
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_assert (
	input logic        clk,
	input logic        rst_n_i,
	input logic        req_i,
	input logic [31:0] addr_i,
	input logic        ack_i,
	input logic        valid_i,
	input logic        freeze_i,
	input logic        flush_i,
	input logic [31:0] pc_i,
	input logic [31:0] insn_i
);

	// Request open, address must not move
	req_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_i && !ack_i |=> req_i && $stable(addr_i))
		else $error("mem_addr_o moved or mem_req_o dropped before mem_ack_i");

	req_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
		req_i && ack_i |=> !req_i)
		else $error("mem_req_o stayed high after mem_ack_i");

	// No new request until ack is released
	req_wait: assert property (@(posedge clk) disable iff (!rst_n_i)
		!req_i && ack_i |=> !req_i)
		else $error("mem_req_o rose while mem_ack_i was still high");

	stage_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_i && freeze_i && !flush_i |=>
			flush_i || (valid_i && $stable(pc_i) && $stable(insn_i)))
		else $error("held word changed under freeze");

endmodule

bind ifu_imem_port ifu_assert u_hs_assert (
	.clk (clk), .rst_n_i (rst_n_i),
	.req_i (mem_req_o), .addr_i (mem_addr_o), .ack_i (mem_ack_i),
	.valid_i (1'b0), .freeze_i (1'b0), .flush_i (1'b0),
	.pc_i (32'h0), .insn_i (`IFU_NOP_BUBBLE)
);

bind ifu_stage ifu_assert u_stage_assert (
	.clk (clk), .rst_n_i (rst_n_i),
	.req_i (1'b0), .addr_i (32'h0), .ack_i (1'b0),
	.valid_i (fetch_o.valid), .freeze_i (freeze_i), .flush_i (flush_i),
	.pc_i (fetch_o.pc), .insn_i (fetch_o.insn.raw)
);

//--- sim/ifu_tb.sv
// Fetch unit testbench: memory responder, random stimulus, pc reference model
`timescale 1ns/1ps
`include "ifu_cfg.svh"

module ifu_tb;

	// 300 deliveries at 20 cycles each
	localparam int TIMEOUT_CYCLES = 300 * 20;

	logic clk = 1'b0;
	logic rst_n_i;
	ifu_pkg::cfg_wr_t cfg_wr;
	ifu_pkg::fetch_out_t fetch_o;
	logic freeze, flush, mem_req, mem_ack, mem_err;
	logic [31:0] flush_pc, mem_addr, mem_data;
	logic [3:0] mem_tag;
	logic [31:0] table_mem [0:1023];
	integer seed;
	int errors, checks, delivered, cycle_cnt, delay;
	bit pending, held;
	bit timed_out = 1'b0;
	// Model state and the last response handed out
	logic [31:0] exp_pc, base_model;
	logic rsp_err;
	logic [3:0] rsp_tag;

	ifu_top UUT (
		.clk (clk), .rst_n_i (rst_n_i), .cfg_wr_i (cfg_wr),
		.freeze_i (freeze), .flush_i (flush), .flush_pc_i (flush_pc),
		.mem_req_o (mem_req), .mem_addr_o (mem_addr), .mem_ack_i (mem_ack),
		.mem_data_i (mem_data), .mem_err_i (mem_err), .mem_tag_i (mem_tag),
		.fetch_o (fetch_o)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return table_mem[addr[11:2]];
	endfunction

	// Returned as {be, pe, te}
	function automatic logic [2:0] tag_flags(input logic [3:0] tag);
		return {tag == `IFU_TAG_BE, tag == `IFU_TAG_PE, tag == `IFU_TAG_TE};
	endfunction

	function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] insn,
			input logic [2:0] flg);
		if (flg[0]) return base_model + `IFU_VEC_TE;
		if (flg[1]) return base_model + `IFU_VEC_PE;
		if (flg[2]) return base_model + `IFU_VEC_BE;
		// Jump displacement counts words
		if (insn[31:26] == `IFU_OP_JMP) return pc + {{4{insn[25]}}, insn[25:0], 2'b00};
		return pc + 32'd4;
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error t=%0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// About one word in eight is a short jump
	task automatic build_table();
		logic [31:0] w;
		for (int i = 0; i < 1024; i++) begin
			w = $random(seed);
			if ($unsigned($random(seed)) % 8 == 0)
				w = {`IFU_OP_JMP, {20{w[5]}}, w[5:0]};
			else if (w[31:26] == `IFU_OP_JMP)
				w[31:26] = 6'h01;
			table_mem[i] = w;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory responder and stimulus, both on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic respond_memory();
		if (mem_ack) begin
			// Four-phase release
			if (!mem_req) mem_ack = 1'b0;
		end else if (mem_req) begin
			if (!pending) begin
				pending = 1'b1;
				delay = $unsigned($random(seed)) % 6;
			end
			if (delay == 0) begin
				pending = 1'b0;
				rsp_err = ($unsigned($random(seed)) % 10) == 0;
				rsp_tag = $random(seed);
				case (rsp_tag[1:0])
					2'd0: rsp_tag = `IFU_TAG_TE;
					2'd1: rsp_tag = `IFU_TAG_PE;
					2'd2: rsp_tag = `IFU_TAG_BE;
					default: ;
				endcase
				mem_data = rsp_err ? $random(seed) : mem_word(mem_addr);
				mem_err = rsp_err;
				mem_tag = rsp_tag;
				mem_ack = 1'b1;
			end else begin
				delay--;
			end
		end
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		r = $random(seed);
		freeze = (r[1:0] == 2'd0);
		flush = (r[9:4] == 6'd0);
		flush_pc = $random(seed) & 32'h0000_0ffc;
		cfg_wr.en = (r[14:10] == 5'd0);
		cfg_wr.sel = r[15];
		cfg_wr.data = $random(seed);
	endtask

	task automatic check_outputs();
		logic [31:0] exp_insn;
		logic [2:0] exp_flg;
		if (flush) begin
			compare("fetch_o.valid", fetch_o.valid, 1'b0);
			compare("fetch_o.insn", fetch_o.insn.raw, `IFU_NOP_FLUSH);
			exp_pc = flush_pc;
			held = 1'b0;
		end else begin
			// Word held under freeze stays valid
			if (held) compare("fetch_o.valid", fetch_o.valid, 1'b1);
			if (fetch_o.valid) begin
				exp_flg = rsp_err ? tag_flags(rsp_tag) : 3'b000;
				exp_insn = rsp_err ? `IFU_NOP_FLUSH : mem_word(exp_pc);
				compare("fetch_o.pc", fetch_o.pc, exp_pc);
				compare("fetch_o.insn", fetch_o.insn.raw, exp_insn);
				compare("fetch_o {be,pe,te}", {fetch_o.be, fetch_o.pe, fetch_o.te}, exp_flg);
				if (freeze) begin
					compare("mem_req_o", mem_req, 1'b0);
				end else begin
					delivered++;
					exp_pc = next_pc(exp_pc, exp_insn, exp_flg);
				end
			end else begin
				compare("fetch_o.insn", fetch_o.insn.raw, `IFU_NOP_BUBBLE);
			end
			held = fetch_o.valid && freeze;
		end
		// Base write lands at the coming edge
		if (cfg_wr.en && cfg_wr.sel) base_model = {cfg_wr.data[31:2], 2'b00};
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n_i = 1'b0;
		freeze = 1'b0;
		flush = 1'b0;
		cfg_wr = '0;
		{mem_ack, mem_err, mem_tag, mem_data} = '0;
		pending = 1'b0;
		repeat (16) begin
			#1;
			compare("mem_req_o", mem_req, 1'b0);
			compare("fetch_o.valid", fetch_o.valid, 1'b0);
			compare("fetch_o {be,pe,te}", {fetch_o.be, fetch_o.pe, fetch_o.te}, 3'b000);
			@(negedge clk);
		end
		rst_n_i = 1'b1;
		exp_pc = `IFU_RST_VEC;
		base_model = `IFU_EXC_BASE_RST;
		held = 1'b0;
	endtask

	task automatic run_phase(input int n);
		int start;
		start = delivered;
		while (delivered - start < n) begin
			@(negedge clk);
			respond_memory();
			drive_inputs();
			#1;
			check_outputs();
		end
	endtask

	task automatic finish_run();
		$display("checks %0d errors %0d deliveries %0d timeout %0d",
			checks, errors, delivered, timed_out);
		if (errors == 0 && !timed_out)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence and watchdog
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 83239;
		rst_n_i = 1'b0;
		{freeze, flush, flush_pc, cfg_wr} = '0;
		{mem_ack, mem_err, mem_tag, mem_data} = '0;
		build_table();
		apply_reset();
		run_phase(250);
		// Rewrite the reset vector, unaligned on purpose
		@(negedge clk);
		{freeze, flush} = 2'b00;
		cfg_wr.en = 1'b1;
		cfg_wr.sel = 1'b0;
		cfg_wr.data = 32'h0000_0349;
		@(negedge clk);
		cfg_wr.en = 1'b0;
		#1;
		compare("reset_vec_o", UUT.u_cfg_regs.reset_vec_o, 32'h0000_0348);
		// Register returns to its reset value with the core
		apply_reset();
		run_phase(50);
		finish_run();
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		timed_out = 1'b1;
		$display("timeout after %0d cycles before all deliveries were seen", cycle_cnt);
		finish_run();
	end

endmodule

//--- tb.f
+incdir+verilog
verilog/ifu_pkg.sv
verilog/ifu_cfg_regs.sv
verilog/ifu_pc_gen.sv
verilog/ifu_imem_port.sv
verilog/ifu_stage.sv
verilog/ifu_top.sv
sim/ifu_assert.sv
sim/ifu_tb.sv

//--- Bender.yml
package:
  name: ifu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ifu_pkg.sv
      - verilog/ifu_cfg_regs.sv
      - verilog/ifu_pc_gen.sv
      - verilog/ifu_imem_port.sv
      - verilog/ifu_stage.sv
      - verilog/ifu_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/ifu_assert.sv
      - sim/ifu_tb.sv
